/* filelist.f */
rtl/cpu_pkg.sv
rtl/stage_if.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/cpu_top.sv
sim/tb_clock.sv
sim/cpu_properties.sv
sim/cpu_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
rm -f sim.log
verilator --binary --timing --assert --top-module cpu_tb -f filelist.f -o cpu_sim \
	|| { echo "verilator build failed"; exit 1; }
{ ./obj_dir/cpu_sim 2>&1 || echo "test failed"; } | tee sim.log
grep -q "test failed" sim.log && exit 1 || exit 0

/* sim/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;

	localparam int prog_len = 28;
	localparam int mem_bits = 6;
	localparam int mem_depth = 1 << mem_bits;
	localparam int cycle_limit = 4 * prog_len + 50;
	// cycles to keep watching once halted
	localparam int halt_linger = 8;

	logic clk;
	logic reset_n;
	logic inst_read;
	word_t inst_addr;
	word_t inst_data;
	logic data_read;
	logic data_write;
	word_t data_addr;
	word_t data_wdata;
	word_t data_rdata;
	word_t num_inst;
	word_t output_port;
	logic is_halted;

	word_t imem [mem_depth];
	word_t dmem [mem_depth];
	word_t model_mem [mem_depth];
	// output port values in the order they should appear
	word_t expected_out [$];
	int expected_count;
	logic [31:0] lcg_state;
	int error_count;
	int timeout_count;
	int cycle_count;
	int out_index;
	int halted_cycles;
	word_t last_port;
	logic halt_prev;
	logic finished;

	tb_clock clock0 (
		.clk_o(clk),
		.reset_n_o(reset_n)
	);

	cpu_top #(
		.reset_pc(16'h0000)
	) dut0 (
		.clk(clk),
		.reset_n(reset_n),
		.inst_read_o(inst_read),
		.inst_addr_o(inst_addr),
		.inst_data_i(inst_data),
		.data_read_o(data_read),
		.data_write_o(data_write),
		.data_addr_o(data_addr),
		.data_wdata_o(data_wdata),
		.data_rdata_i(data_rdata),
		.num_inst_o(num_inst),
		.output_port_o(output_port),
		.is_halted_o(is_halted)
	);

	// both memories answer within the cycle
	assign inst_data = inst_read ? imem[inst_addr[mem_bits-1:0]] : '0;
	assign data_rdata = data_read ? dmem[data_addr[mem_bits-1:0]] : '0;

	always @(posedge clk) begin
		if (data_write)
			dmem[data_addr[mem_bits-1:0]] <= data_wdata;
	end

	function automatic logic [7:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	function automatic word_t imm_inst(input opcode_e op, input reg_addr_t rs,
		input reg_addr_t rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t reg_inst(input reg_addr_t rs, input reg_addr_t rt,
		input reg_addr_t rd, input func_e fn);
		return {op_rtype, rs, rt, rd, fn};
	endfunction

	function automatic word_t jump_inst(input logic [11:0] target);
		return {op_jmp, target};
	endfunction

	task automatic preload_data();
		logic [7:0] hi;
		logic [7:0] lo;
		for (int i = 0; i < mem_depth; i++) begin
			hi = next_random();
			lo = next_random();
			dmem[i[mem_bits-1:0]] <= {hi, lo};
			model_mem[i[mem_bits-1:0]] = {hi, lo};
		end
	endtask

	task automatic build_program();
		logic [7:0] k_hi;
		logic [7:0] k_lo;
		logic [7:0] k_add;
		logic [7:0] k_tgt;
		logic [7:0] ld_off;
		logic [7:0] st_a;
		logic [7:0] st_b;
		logic [7:0] st_c;
		k_hi = next_random();
		k_lo = next_random();
		k_add = next_random();
		k_tgt = next_random();
		// load from the low quarter and store into the three upper ones
		ld_off = next_random() % 8'd16;
		st_a = 8'd16 + next_random() % 8'd16;
		st_b = 8'd32 + next_random() % 8'd16;
		st_c = 8'd48 + next_random() % 8'd16;
		// unused slots halt and carry their address in the register fields
		for (int i = 0; i < mem_depth; i++)
			imem[i[mem_bits-1:0]] = reg_inst(i[5:4], i[3:2], i[1:0], fn_hlt);
		imem[0] = imm_inst(op_lhi, 2'd0, 2'd0, k_hi);
		imem[1] = imm_inst(op_ori, 2'd0, 2'd0, k_lo);
		imem[2] = reg_inst(2'd0, 2'd0, 2'd0, fn_wwd);
		imem[3] = imm_inst(op_adi, 2'd0, 2'd1, k_add);
		// r3 is still zero from reset
		imem[4] = imm_inst(op_lwd, 2'd3, 2'd2, ld_off);
		imem[5] = reg_inst(2'd2, 2'd0, 2'd0, fn_wwd);
		imem[6] = reg_inst(2'd1, 2'd2, 2'd3, fn_add);
		imem[7] = reg_inst(2'd3, 2'd1, 2'd0, fn_sub);
		imem[8] = reg_inst(2'd0, 2'd0, 2'd0, fn_wwd);
		imem[9] = reg_inst(2'd0, 2'd3, 2'd1, fn_and);
		imem[10] = reg_inst(2'd1, 2'd0, 2'd2, fn_orr);
		imem[11] = reg_inst(2'd2, 2'd0, 2'd3, fn_not);
		imem[12] = reg_inst(2'd1, 2'd0, 2'd0, fn_wwd);
		imem[13] = reg_inst(2'd2, 2'd0, 2'd0, fn_wwd);
		imem[14] = reg_inst(2'd3, 2'd0, 2'd0, fn_wwd);
		imem[15] = imm_inst(op_lhi, 2'd0, 2'd0, 8'd0);
		imem[16] = imm_inst(op_swd, 2'd0, 2'd3, st_a);
		imem[17] = imm_inst(op_swd, 2'd0, 2'd2, st_b);
		imem[18] = imm_inst(op_lwd, 2'd0, 2'd1, st_a);
		imem[19] = reg_inst(2'd1, 2'd0, 2'd0, fn_wwd);
		imem[20] = jump_inst(12'd23);
		// squashed and skipped slots
		imem[21] = reg_inst(2'd2, 2'd0, 2'd0, fn_wwd);
		imem[22] = imm_inst(op_adi, 2'd2, 2'd2, 8'd1);
		imem[23] = imm_inst(op_adi, 2'd1, 2'd2, k_tgt);
		imem[24] = reg_inst(2'd2, 2'd0, 2'd0, fn_wwd);
		imem[25] = imm_inst(op_swd, 2'd0, 2'd2, st_c);
		imem[26] = reg_inst(2'd0, 2'd0, 2'd0, fn_hlt);
		imem[27] = reg_inst(2'd0, 2'd0, 2'd0, fn_wwd);
	endtask

	// sequential instruction-set model stepping one instruction at a time
	task automatic run_model();
		word_t regs [4];
		word_t pc;
		word_t cur_pc;
		word_t inst;
		word_t a;
		word_t b;
		word_t simm;
		word_t ea;
		word_t last_out;
		opcode_e op;
		func_e fn;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic running;
		for (int i = 0; i < 4; i++)
			regs[i[1:0]] = '0;
		pc = '0;
		last_out = '0;
		running = 1'b1;
		expected_count = 0;
		while (running && expected_count < 4 * mem_depth) begin
			cur_pc = pc;
			inst = imem[pc[mem_bits-1:0]];
			op = opcode_e'(inst[15:12]);
			fn = func_e'(inst[5:0]);
			rs = inst[11:10];
			rt = inst[9:8];
			rd = inst[7:6];
			a = regs[rs];
			b = regs[rt];
			simm = {{8{inst[7]}}, inst[7:0]};
			ea = a + simm;
			pc = pc + 16'd1;
			expected_count++;
			case (op)
				op_adi: regs[rt] = a + simm;
				op_ori: regs[rt] = a | {8'h00, inst[7:0]};
				op_lhi: regs[rt] = {inst[7:0], 8'h00};
				op_lwd: regs[rt] = model_mem[ea[mem_bits-1:0]];
				op_swd: model_mem[ea[mem_bits-1:0]] = b;
				op_jmp: pc = {cur_pc[15:12], inst[11:0]};
				op_rtype: begin
					case (fn)
						fn_add: regs[rd] = a + b;
						fn_sub: regs[rd] = a - b;
						fn_and: regs[rd] = a & b;
						fn_orr: regs[rd] = a | b;
						fn_not: regs[rd] = ~a;
						fn_wwd: begin
							// a repeated value leaves the port unchanged
							if (a != last_out) begin
								expected_out.push_back(a);
								last_out = a;
							end
						end
						fn_hlt: running = 1'b0;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	endtask

	task automatic check_cycle();
		if (output_port != last_port) begin
			assert (out_index < expected_out.size())
			else begin
				error_count++;
				$display("output port changed more often than the program writes it");
			end
			if (out_index < expected_out.size()) begin
				assert (output_port == expected_out[out_index])
				else begin
					error_count++;
					$display("Error at %0d ns: output port %h, expected %h",
						$time, output_port, expected_out[out_index]);
				end
			end
			out_index++;
			last_port = output_port;
		end
		if (data_read || data_write) begin
			assert (data_addr < word_t'(mem_depth))
			else begin
				error_count++;
				$display("Error at %0d ns: data address %h outside the modelled memory",
					$time, data_addr);
			end
		end
		if (is_halted && !halt_prev) begin
			assert (num_inst == word_t'(expected_count))
			else begin
				error_count++;
				$display("Error at %0d ns: retired count %0d at halt, expected %0d",
					$time, num_inst, expected_count);
			end
			assert (out_index == expected_out.size())
			else begin
				error_count++;
				$display("processor halted before all output values appeared");
			end
		end
		if (is_halted)
			halted_cycles++;
		halt_prev = is_halted;
		if (halted_cycles >= halt_linger)
			finished = 1'b1;
	endtask

	task automatic check_memory();
		for (int i = 0; i < mem_depth; i++) begin
			assert (dmem[i[mem_bits-1:0]] == model_mem[i[mem_bits-1:0]])
			else begin
				error_count++;
				$display("Error at %0d ns: data word %0d is %h, expected %h", $time, i,
					dmem[i[mem_bits-1:0]], model_mem[i[mem_bits-1:0]]);
			end
		end
	endtask

	initial begin
		lcg_state = 32'd38;
		error_count = 0;
		timeout_count = 0;
		cycle_count = 0;
		out_index = 0;
		halted_cycles = 0;
		last_port = '0;
		halt_prev = 1'b0;
		finished = 1'b0;
		preload_data();
		build_program();
		run_model();
		@(posedge reset_n);
		while (!finished && cycle_count < cycle_limit) begin
			@(negedge clk);
			cycle_count++;
			check_cycle();
		end
		if (finished) begin
			check_memory();
		end else begin
			timeout_count++;
			$display("Timeout: processor did not halt within %0d cycles", cycle_limit);
		end
		$display("errors: %0d, timeouts: %0d", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* sim/cpu_properties.sv */
`timescale 1ns/1ps

module cpu_properties (
	input logic clk,
	input logic reset_n,
	input logic inst_read_i,
	input logic data_read_i,
	input logic data_write_i,
	input cpu_pkg::word_t num_inst_i,
	input cpu_pkg::word_t output_port_i,
	input logic is_halted_i
);

	// first cycle after reset has no fetch and no memory traffic
	reset_quiet: assert property (@(posedge clk)
		!reset_n |=> (!inst_read_i && !data_read_i && !data_write_i && !is_halted_i
			&& num_inst_i == '0 && output_port_i == '0))
		else $error("outputs not idle right after reset");

	// port and halt flag only move on retirement
	idle_before_retire: assert property (@(posedge clk) disable iff (!reset_n)
		num_inst_i == '0 |-> (!is_halted_i && output_port_i == '0))
		else $error("port or halt flag moved before any instruction retired");

	halt_sticky: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted_i |=> is_halted_i)
		else $error("halt flag dropped without reset");

	count_frozen: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted_i |=> $stable(num_inst_i))
		else $error("retired count moved after halt");

	no_fetch_halted: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted_i |-> !inst_read_i)
		else $error("instruction read while halted");

	strobes_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
		!(data_read_i && data_write_i))
		else $error("data read and write strobes high together");

endmodule

bind cpu_top cpu_properties props0 (
	.clk(clk),
	.reset_n(reset_n),
	.inst_read_i(inst_read_o),
	.data_read_i(data_read_o),
	.data_write_i(data_write_o),
	.num_inst_i(num_inst_o),
	.output_port_i(output_port_o),
	.is_halted_i(is_halted_o)
);

/* sim/tb_clock.sv */
`timescale 1ns/1ps

// free-running clock, reset held low for the first few edges
module tb_clock #(
	parameter int half_period = 20,
	parameter int reset_cycles = 3
) (
	output logic clk_o,
	output logic reset_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #half_period clk_o = ~clk_o;
	end

	initial begin
		reset_n_o = 1'b0;
		repeat (reset_cycles) @(posedge clk_o);
		reset_n_o <= 1'b1;
	end

endmodule

/* rtl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
	parameter cpu_pkg::word_t reset_pc = '0
) (
	input  logic clk,
	input  logic reset_n,
	output logic inst_read_o,
	output cpu_pkg::word_t inst_addr_o,
	input  cpu_pkg::word_t inst_data_i,
	output logic data_read_o,
	output logic data_write_o,
	output cpu_pkg::word_t data_addr_o,
	output cpu_pkg::word_t data_wdata_o,
	input  cpu_pkg::word_t data_rdata_i,
	output cpu_pkg::word_t num_inst_o,
	output cpu_pkg::word_t output_port_o,
	output logic is_halted_o
);

	// IF/ID
	cpu_pkg::word_t ifid_inst;
	cpu_pkg::word_t ifid_pc;
	logic ifid_valid;

	// decode to fetch
	logic stall;
	logic redirect;
	cpu_pkg::word_t target;
	logic halt_seen;

	// register file read side
	cpu_pkg::reg_addr_t raddr_a;
	cpu_pkg::reg_addr_t raddr_b;
	cpu_pkg::word_t rdata_a;
	cpu_pkg::word_t rdata_b;

	// ID/EX
	cpu_pkg::ctrl_t idex_ctrl;
	cpu_pkg::word_t idex_a;
	cpu_pkg::word_t idex_b;
	cpu_pkg::word_t idex_imm;
	cpu_pkg::reg_addr_t idex_rs;
	cpu_pkg::reg_addr_t idex_rt;

	wb_if wb_bus ();
	ex_fwd_if exm_bus ();

	fetch_stage #(
		.reset_pc(reset_pc)
	) u_fetch (
		.clk(clk),
		.reset_n(reset_n),
		.inst_data_i(inst_data_i),
		.stall_i(stall),
		.redirect_i(redirect),
		.target_i(target),
		.halt_seen_i(halt_seen),
		.inst_read_o(inst_read_o),
		.inst_addr_o(inst_addr_o),
		.ifid_inst_o(ifid_inst),
		.ifid_pc_o(ifid_pc),
		.ifid_valid_o(ifid_valid)
	);

	decode_stage u_decode (
		.clk(clk),
		.reset_n(reset_n),
		.ifid_inst_i(ifid_inst),
		.ifid_pc_i(ifid_pc),
		.ifid_valid_i(ifid_valid),
		.rdata_a_i(rdata_a),
		.rdata_b_i(rdata_b),
		.raddr_a_o(raddr_a),
		.raddr_b_o(raddr_b),
		.stall_o(stall),
		.redirect_o(redirect),
		.target_o(target),
		.halt_seen_o(halt_seen),
		.idex_ctrl_o(idex_ctrl),
		.idex_a_o(idex_a),
		.idex_b_o(idex_b),
		.idex_imm_o(idex_imm),
		.idex_rs_o(idex_rs),
		.idex_rt_o(idex_rt)
	);

	reg_file u_regs (
		.clk(clk),
		.reset_n(reset_n),
		.raddr_a_i(raddr_a),
		.raddr_b_i(raddr_b),
		.wb(wb_bus.sink),
		.rdata_a_o(rdata_a),
		.rdata_b_o(rdata_b)
	);

	execute_stage u_execute (
		.clk(clk),
		.reset_n(reset_n),
		.idex_ctrl_i(idex_ctrl),
		.idex_a_i(idex_a),
		.idex_b_i(idex_b),
		.idex_imm_i(idex_imm),
		.idex_rs_i(idex_rs),
		.idex_rt_i(idex_rt),
		.wb(wb_bus.sink),
		.exm(exm_bus.source)
	);

	mem_wb_stage u_mem_wb (
		.clk(clk),
		.reset_n(reset_n),
		.data_rdata_i(data_rdata_i),
		.exm(exm_bus.sink),
		.data_read_o(data_read_o),
		.data_write_o(data_write_o),
		.data_addr_o(data_addr_o),
		.data_wdata_o(data_wdata_o),
		.wb(wb_bus.source),
		.num_inst_o(num_inst_o),
		.output_port_o(output_port_o),
		.is_halted_o(is_halted_o)
	);

endmodule

/* rtl/mem_wb_stage.sv */
`timescale 1ns/1ps

module mem_wb_stage (
	input  logic clk,
	input  logic reset_n,
	input  cpu_pkg::word_t data_rdata_i,
	ex_fwd_if.sink exm,
	output logic data_read_o,
	output logic data_write_o,
	output cpu_pkg::word_t data_addr_o,
	output cpu_pkg::word_t data_wdata_o,
	wb_if.source wb,
	output cpu_pkg::word_t num_inst_o,
	output cpu_pkg::word_t output_port_o,
	output logic is_halted_o
);
	import cpu_pkg::*;

	ctrl_t wb_ctrl_q;
	word_t wb_data_q;
	word_t mem_result;

	// data memory answers in the same cycle
	assign data_read_o = exm.ctrl.valid & exm.ctrl.mem_read;
	assign data_write_o = exm.ctrl.valid & exm.ctrl.mem_write;
	assign data_addr_o = exm.result;
	assign data_wdata_o = exm.store_data;

	assign mem_result = exm.ctrl.mem_to_reg ? data_rdata_i : exm.result;

	always_ff @(posedge clk) begin
		if (!reset_n)
			wb_ctrl_q <= '0;
		else
			wb_ctrl_q <= exm.ctrl;
	end

	always_ff @(posedge clk) begin
		wb_data_q <= mem_result;
	end

	assign wb.reg_write = wb_ctrl_q.reg_write;
	assign wb.dest = wb_ctrl_q.dest;
	assign wb.data = wb_data_q;
	assign wb.valid = wb_ctrl_q.valid;

	// retirement at the end of the writeback cycle
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			num_inst_o <= '0;
			output_port_o <= '0;
			is_halted_o <= 1'b0;
		end else if (wb_ctrl_q.valid) begin
			num_inst_o <= num_inst_o + word_t'(1);
			if (wb_ctrl_q.is_wwd)
				output_port_o <= wb_data_q;
			// sticky until reset
			if (wb_ctrl_q.is_halt)
				is_halted_o <= 1'b1;
		end
	end

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
	input  logic clk,
	input  logic reset_n,
	input  cpu_pkg::ctrl_t idex_ctrl_i,
	input  cpu_pkg::word_t idex_a_i,
	input  cpu_pkg::word_t idex_b_i,
	input  cpu_pkg::word_t idex_imm_i,
	input  cpu_pkg::reg_addr_t idex_rs_i,
	input  cpu_pkg::reg_addr_t idex_rt_i,
	wb_if.sink wb,
	ex_fwd_if.source exm
);
	import cpu_pkg::*;

	ctrl_t ex_ctrl_q;
	word_t ex_result_q;
	word_t ex_store_q;
	logic ex_ok;
	logic wb_ok;
	word_t op_a;
	word_t fwd_b;
	word_t op_b;
	word_t alu_out;

	// EX/MEM wins over MEM/WB, which wins over the register value
	function automatic word_t forward(
		input reg_addr_t src,
		input word_t reg_val,
		input logic ex_hit_ok,
		input reg_addr_t ex_dest,
		input word_t ex_val,
		input logic wb_hit_ok,
		input reg_addr_t wb_dest,
		input word_t wb_val
	);
		if (ex_hit_ok && ex_dest == src)
			return ex_val;
		else if (wb_hit_ok && wb_dest == src)
			return wb_val;
		return reg_val;
	endfunction

	// a load in EX/MEM has no data yet, the stall keeps it out of reach
	assign ex_ok = ex_ctrl_q.valid & ex_ctrl_q.reg_write & ~ex_ctrl_q.mem_read;
	assign wb_ok = wb.valid & wb.reg_write;

	assign op_a = forward(idex_rs_i, idex_a_i, ex_ok, ex_ctrl_q.dest, ex_result_q,
		wb_ok, wb.dest, wb.data);
	assign fwd_b = forward(idex_rt_i, idex_b_i, ex_ok, ex_ctrl_q.dest, ex_result_q,
		wb_ok, wb.dest, wb.data);
	assign op_b = idex_ctrl_i.use_imm ? idex_imm_i : fwd_b;

	always_comb begin
		case (idex_ctrl_i.alu_op)
			alu_add: alu_out = op_a + op_b;
			alu_sub: alu_out = op_a - op_b;
			alu_and: alu_out = op_a & op_b;
			alu_or: alu_out = op_a | op_b;
			alu_not: alu_out = ~op_a;
			alu_lhi: alu_out = op_b;
			default: alu_out = op_a;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n)
			ex_ctrl_q <= '0;
		else
			ex_ctrl_q <= idex_ctrl_i;
	end

	always_ff @(posedge clk) begin
		ex_result_q <= alu_out;
		ex_store_q <= fwd_b;
	end

	assign exm.ctrl = ex_ctrl_q;
	assign exm.result = ex_result_q;
	assign exm.store_data = ex_store_q;

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input  logic clk,
	input  logic reset_n,
	input  cpu_pkg::reg_addr_t raddr_a_i,
	input  cpu_pkg::reg_addr_t raddr_b_i,
	wb_if.sink wb,
	output cpu_pkg::word_t rdata_a_o,
	output cpu_pkg::word_t rdata_b_o
);
	import cpu_pkg::*;

	localparam int num_regs = 2 ** reg_addr_width;

	word_t regs [num_regs];
	logic wr_en;

	assign wr_en = wb.valid & wb.reg_write;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < num_regs; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wb.dest] <= wb.data;
		end
	end

	// same-cycle writeback is visible to decode
	assign rdata_a_o = (wr_en && wb.dest == raddr_a_i) ? wb.data : regs[raddr_a_i];
	assign rdata_b_o = (wr_en && wb.dest == raddr_b_i) ? wb.data : regs[raddr_b_i];

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
	input  logic clk,
	input  logic reset_n,
	input  cpu_pkg::word_t ifid_inst_i,
	input  cpu_pkg::word_t ifid_pc_i,
	input  logic ifid_valid_i,
	input  cpu_pkg::word_t rdata_a_i,
	input  cpu_pkg::word_t rdata_b_i,
	output cpu_pkg::reg_addr_t raddr_a_o,
	output cpu_pkg::reg_addr_t raddr_b_o,
	output logic stall_o,
	output logic redirect_o,
	output cpu_pkg::word_t target_o,
	output logic halt_seen_o,
	output cpu_pkg::ctrl_t idex_ctrl_o,
	output cpu_pkg::word_t idex_a_o,
	output cpu_pkg::word_t idex_b_o,
	output cpu_pkg::word_t idex_imm_o,
	output cpu_pkg::reg_addr_t idex_rs_o,
	output cpu_pkg::reg_addr_t idex_rt_o
);
	import cpu_pkg::*;

	localparam int imm_width = imm_msb - imm_lsb + 1;

	opcode_e opcode;
	func_e func;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	logic [imm_width-1:0] imm8;
	word_t imm;
	ctrl_t ctrl;
	logic uses_a;
	logic uses_b;
	logic halt_now;
	logic halt_q;

	assign opcode = opcode_e'(ifid_inst_i[opcode_msb:opcode_lsb]);
	assign func = func_e'(ifid_inst_i[func_msb:func_lsb]);
	assign rs = ifid_inst_i[rs_msb:rs_lsb];
	assign rt = ifid_inst_i[rt_msb:rt_lsb];
	assign rd = ifid_inst_i[rd_msb:rd_lsb];
	assign imm8 = ifid_inst_i[imm_msb:imm_lsb];

	assign raddr_a_o = rs;
	assign raddr_b_o = rt;

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = alu_add;
		uses_a = 1'b0;
		uses_b = 1'b0;
		case (opcode)
			op_adi, op_ori, op_lwd: begin
				ctrl.reg_write = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.dest = rt;
				uses_a = 1'b1;
				if (opcode == op_ori)
					ctrl.alu_op = alu_or;
				if (opcode == op_lwd) begin
					ctrl.mem_read = 1'b1;
					ctrl.mem_to_reg = 1'b1;
				end
			end
			op_lhi: begin
				ctrl.reg_write = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.alu_op = alu_lhi;
				ctrl.dest = rt;
			end
			op_swd: begin
				ctrl.mem_write = 1'b1;
				ctrl.use_imm = 1'b1;
				uses_a = 1'b1;
				uses_b = 1'b1;
			end
			op_rtype: begin
				uses_a = 1'b1;
				ctrl.dest = rd;
				case (func)
					fn_add, fn_sub, fn_and, fn_orr: begin
						ctrl.reg_write = 1'b1;
						uses_b = 1'b1;
						ctrl.alu_op = (func == fn_add) ? alu_add :
							(func == fn_sub) ? alu_sub :
							(func == fn_and) ? alu_and : alu_or;
					end
					fn_not: begin
						ctrl.reg_write = 1'b1;
						ctrl.alu_op = alu_not;
					end
					fn_wwd: begin
						ctrl.is_wwd = 1'b1;
						ctrl.alu_op = alu_pass_a;
					end
					fn_hlt: begin
						ctrl.is_halt = 1'b1;
						uses_a = 1'b0;
					end
					default: uses_a = 1'b0;
				endcase
			end
			default: ;
		endcase
		ctrl.valid = ifid_valid_i;
		if (!ifid_valid_i)
			ctrl = '0;
	end

	// ORI zero-extends, LHI fills the high byte, the rest sign-extend
	always_comb begin
		case (opcode)
			op_ori: imm = {{(word_width-imm_width){1'b0}}, imm8};
			op_lhi: imm = {imm8, {(word_width-imm_width){1'b0}}};
			default: imm = {{(word_width-imm_width){imm8[imm_width-1]}}, imm8};
		endcase
	end

	// load in EX whose result this instruction needs
	assign stall_o = ifid_valid_i && idex_ctrl_o.valid && idex_ctrl_o.mem_read &&
		((uses_a && idex_ctrl_o.dest == rs) || (uses_b && idex_ctrl_o.dest == rt));

	assign redirect_o = ifid_valid_i && opcode == op_jmp;
	assign target_o = {ifid_pc_i[word_width-1:target_msb+1], ifid_inst_i[target_msb:target_lsb]};

	assign halt_now = ctrl.is_halt;
	assign halt_seen_o = halt_q | halt_now;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			halt_q <= 1'b0;
			idex_ctrl_o <= '0;
		end else begin
			halt_q <= halt_seen_o;
			idex_ctrl_o <= stall_o ? '0 : ctrl;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		idex_a_o <= rdata_a_i;
		idex_b_o <= rdata_b_i;
		idex_imm_o <= imm;
		idex_rs_o <= rs;
		idex_rt_o <= rt;
	end

endmodule

/* rtl/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage #(
	parameter cpu_pkg::word_t reset_pc = '0
) (
	input  logic clk,
	input  logic reset_n,
	input  cpu_pkg::word_t inst_data_i,
	input  logic stall_i,
	input  logic redirect_i,
	input  cpu_pkg::word_t target_i,
	input  logic halt_seen_i,
	output logic inst_read_o,
	output cpu_pkg::word_t inst_addr_o,
	output cpu_pkg::word_t ifid_inst_o,
	output cpu_pkg::word_t ifid_pc_o,
	output logic ifid_valid_o
);
	import cpu_pkg::*;

	word_t pc;
	// first cycle after reset has no fetch
	logic fetch_on;

	assign inst_addr_o = pc;
	assign inst_read_o = fetch_on & ~halt_seen_i;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= reset_pc;
			fetch_on <= 1'b0;
			ifid_valid_o <= 1'b0;
		end else begin
			fetch_on <= 1'b1;
			if (redirect_i) begin
				// jump resolved in decode, squash the slot behind it
				pc <= target_i;
				ifid_valid_o <= 1'b0;
			end else if (halt_seen_i || !fetch_on) begin
				ifid_valid_o <= 1'b0;
			end else if (!stall_i) begin
				pc <= pc + word_t'(1);
				ifid_valid_o <= 1'b1;
			end
		end
	end

	// IF/ID payload
	always_ff @(posedge clk) begin
		if (!stall_i) begin
			ifid_inst_o <= inst_data_i;
			ifid_pc_o <= pc;
		end
	end

endmodule

/* rtl/stage_if.sv */
`timescale 1ns/1ps

// writeback path, shared by the register file and MEM/WB forwarding
interface wb_if;
	import cpu_pkg::*;

	logic reg_write;
	reg_addr_t dest;
	word_t data;
	logic valid;

	modport source (
		output reg_write,
		output dest,
		output data,
		output valid
	);

	modport sink (
		input reg_write,
		input dest,
		input data,
		input valid
	);
endinterface

// EX/MEM register contents seen by the memory stage
interface ex_fwd_if;
	import cpu_pkg::*;

	ctrl_t ctrl;
	word_t result;
	word_t store_data;

	modport source (
		output ctrl,
		output result,
		output store_data
	);

	modport sink (
		input ctrl,
		input result,
		input store_data
	);
endinterface

/* rtl/cpu_pkg.sv */
package cpu_pkg;

	localparam int word_width = 16;
	localparam int reg_addr_width = 2;

	typedef logic [word_width-1:0] word_t;
	typedef logic [reg_addr_width-1:0] reg_addr_t;

	// instruction field positions
	localparam int opcode_msb = 15;
	localparam int opcode_lsb = 12;
	localparam int rs_msb = 11;
	localparam int rs_lsb = 10;
	localparam int rt_msb = 9;
	localparam int rt_lsb = 8;
	localparam int rd_msb = 7;
	localparam int rd_lsb = 6;
	localparam int func_msb = 5;
	localparam int func_lsb = 0;
	localparam int imm_msb = 7;
	localparam int imm_lsb = 0;
	localparam int target_msb = 11;
	localparam int target_lsb = 0;

	typedef enum logic [3:0] {
		op_adi = 4'd4,
		op_ori = 4'd5,
		op_lhi = 4'd6,
		op_lwd = 4'd7,
		op_swd = 4'd8,
		op_jmp = 4'd9,
		op_rtype = 4'd15
	} opcode_e;

	// function codes under op_rtype
	typedef enum logic [5:0] {
		fn_add = 6'd0,
		fn_sub = 6'd1,
		fn_and = 6'd2,
		fn_orr = 6'd3,
		fn_not = 6'd4,
		fn_wwd = 6'd28,
		fn_hlt = 6'd29
	} func_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_not,
		alu_lhi,
		alu_pass_a
	} alu_op_e;

	// control word carried by every stage register
	typedef struct packed {
		logic valid;
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic mem_to_reg;
		logic use_imm;
		logic is_wwd;
		logic is_halt;
		alu_op_e alu_op;
		reg_addr_t dest;
	} ctrl_t;

endpackage
